// ==== memPkg.sv ====
`default_nettype none

package memPkg;

  // ------------------------------------------------------------
  // Access size.
  // ------------------------------------------------------------

  // Encoding 2'd3 is not a legal access size.
  typedef enum logic [1:0] {
    memByte = 2'd0,
    memHalf = 2'd1,
    memWord = 2'd2
  } memSizeT;

  // ------------------------------------------------------------
  // Lane geometry.
  // ------------------------------------------------------------

  // Byte lanes per memory word.
  localparam int laneCount = 4;

  // Bits held by one lane.
  localparam int byteWidth = 8;

  // Width of a full data word.
  localparam int wordWidth = laneCount * byteWidth;

  // Address bits that select the byte within a word.
  localparam int offsetWidth = $clog2(laneCount);

endpackage

`default_nettype wire

// ==== byteRam.sv ====
`default_nettype none

// One byte lane of the data memory.
module byteRam #(
  parameter int addrWidth = 11
) (
  input  logic                         clk,
  input  logic                         we,
  input  logic [addrWidth-1:0]         addr,
  input  logic [memPkg::byteWidth-1:0] wd,
  output logic [memPkg::byteWidth-1:0] rd
);

  import memPkg::*;

  // ------------------------------------------------------------
  // Storage.
  // ------------------------------------------------------------

  localparam int depth = 2 ** addrWidth;

  // Contents are undefined until written.
  logic [byteWidth-1:0] mem [depth];

  // ------------------------------------------------------------
  // Read and write port.
  // ------------------------------------------------------------

  // Read before write.
  // The read register samples the old byte at the same edge
  // that stores the new one.
  always_ff @(posedge clk) begin
    rd <= mem[addr];
    if (we) begin
      mem[addr] <= wd;
    end
  end

endmodule

`default_nettype wire

// ==== storeSteer.sv ====
`default_nettype none

// Write-side steering for the four byte lanes.
module storeSteer #(
  parameter int sizeLog2 = 13
) (
  input  logic                                             we,
  input  memPkg::memSizeT                                  memSize,
  input  logic [sizeLog2-1:0]                              addr,
  input  logic [memPkg::wordWidth-1:0]                     wd,
  output logic [memPkg::laneCount-1:0]                     laneWe,
  output logic [memPkg::laneCount-1:0][memPkg::byteWidth-1:0] laneWd,
  output logic [memPkg::laneCount-1:0][sizeLog2-memPkg::offsetWidth-1:0] laneAddr
);

  import memPkg::*;

  localparam int wordAddrWidth = sizeLog2 - offsetWidth;

  // ------------------------------------------------------------
  // Address split.
  // ------------------------------------------------------------

  logic [offsetWidth-1:0]   offset;
  logic [wordAddrWidth-1:0] curWord;
  logic [wordAddrWidth-1:0] nextWord;

  assign offset  = addr[offsetWidth-1:0];
  assign curWord = addr[sizeLog2-1:offsetWidth];

  // Wraps to word zero past the top of memory.
  assign nextWord = curWord + 1'b1;

  // ------------------------------------------------------------
  // Lane enables.
  // ------------------------------------------------------------

  logic [laneCount-1:0]   sizeMask;
  logic [2*laneCount-1:0] maskPair;

  // Bytes covered by the access, counted from the offset.
  always_comb begin
    case (memSize)
      memByte: sizeMask = laneCount'(1);
      memHalf: sizeMask = laneCount'(3);
      memWord: sizeMask = '1;
      default: sizeMask = '0;
    endcase
  end

  // Rotate left by the offset.
  // The upper half of the doubled mask holds the wrapped result.
  assign maskPair = {sizeMask, sizeMask} << offset;
  assign laneWe   = we ? maskPair[2*laneCount-1:laneCount] : '0;

  // ------------------------------------------------------------
  // Write data.
  // ------------------------------------------------------------

  logic [2*wordWidth-1:0] dataPair;

  // Same rotation as the mask, one byte per lane position.
  assign dataPair = {wd, wd} << (offset * byteWidth);
  assign laneWd   = dataPair[2*wordWidth-1:wordWidth];

  // ------------------------------------------------------------
  // Lane word addresses.
  // ------------------------------------------------------------

  // Lanes below the offset hold the bytes that spilled into the
  // following word.
  always_comb begin
    for (int i = 0; i < laneCount; i++) begin
      if (i < int'(offset)) begin
        laneAddr[i] = nextWord;
      end else begin
        laneAddr[i] = curWord;
      end
    end
  end

  // ------------------------------------------------------------
  // Checks.
  // ------------------------------------------------------------

  // A bad size on a write would silently leave memory untouched.
  always_comb begin
    if (we) begin
      assert final (memSize inside {memByte, memHalf, memWord})
        else $error("storeSteer: illegal access size on a write");
    end
  end

endmodule

`default_nettype wire

// ==== loadFormat.sv ====
`default_nettype none

// Read-side alignment and extension.
module loadFormat (
  input  logic                                             clk,
  input  logic                                             rstN,
  input  memPkg::memSizeT                                  memSize,
  input  logic                                             memSigned,
  input  logic [memPkg::offsetWidth-1:0]                   offset,
  input  logic [memPkg::laneCount-1:0][memPkg::byteWidth-1:0] laneRd,
  output logic [memPkg::wordWidth-1:0]                     rd
);

  import memPkg::*;

  // ------------------------------------------------------------
  // Read attributes.
  // ------------------------------------------------------------

  memSizeT                sizeQ;
  logic                   signedQ;
  logic [offsetWidth-1:0] offsetQ;

  // Sampled on the same edge as the lane read registers, so the
  // attributes line up with laneRd in the following cycle.
  always_ff @(posedge clk) begin
    if (!rstN) begin
      sizeQ   <= memByte;
      signedQ <= 1'b0;
      offsetQ <= '0;
    end else begin
      sizeQ   <= memSize;
      signedQ <= memSigned;
      offsetQ <= offset;
    end
  end

  // ------------------------------------------------------------
  // Byte rotation.
  // ------------------------------------------------------------

  logic [2*wordWidth-1:0] lanePair;
  logic [wordWidth-1:0]   aligned;

  // Rotate right so the addressed byte lands in lane 0.
  // Bytes past lane 3 come back around from lane 0.
  assign lanePair = {laneRd, laneRd} >> (offsetQ * byteWidth);
  assign aligned  = lanePair[wordWidth-1:0];

  // ------------------------------------------------------------
  // Extension.
  // ------------------------------------------------------------

  logic byteTop;
  logic halfTop;

  // Fill bit is zero for unsigned loads.
  assign byteTop = signedQ & aligned[byteWidth-1];
  assign halfTop = signedQ & aligned[2*byteWidth-1];

  always_comb begin
    case (sizeQ)
      memByte: rd = {{(wordWidth - byteWidth){byteTop}}, aligned[byteWidth-1:0]};
      memHalf: rd = {{(wordWidth - 2*byteWidth){halfTop}}, aligned[2*byteWidth-1:0]};
      default: rd = aligned;
    endcase
  end

  // ------------------------------------------------------------
  // Checks.
  // ------------------------------------------------------------

  // Reads are never steered, so this is the only guard on the
  // size presented with a plain load.
  property legalSizeRunning;
    @(posedge clk) rstN |=> sizeQ inside {memByte, memHalf, memWord};
  endproperty

  assert property (legalSizeRunning)
    else $error("loadFormat: illegal access size on a read");

endmodule

`default_nettype wire

// ==== memory.sv ====
`default_nettype none

// Byte-addressed data memory built from four byte lanes.
module memory #(
  parameter int sizeLog2 = 13
) (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         we,
  input  memPkg::memSizeT              memSize,
  input  logic                         memSigned,
  input  logic [sizeLog2-1:0]          addr,
  input  logic [memPkg::wordWidth-1:0] wd,
  output logic [memPkg::wordWidth-1:0] rd
);

  import memPkg::*;

  // Word address width of one lane.
  localparam int laneAddrWidth = sizeLog2 - offsetWidth;

  logic [laneCount-1:0]                     laneWe;
  logic [laneCount-1:0][byteWidth-1:0]      laneWd;
  logic [laneCount-1:0][laneAddrWidth-1:0]  laneAddr;
  logic [laneCount-1:0][byteWidth-1:0]      laneRd;

  // ------------------------------------------------------------
  // Write steering.
  // ------------------------------------------------------------

  storeSteer #(
    .sizeLog2(sizeLog2)
  ) u_store (
    .we      (we),
    .memSize (memSize),
    .addr    (addr),
    .wd      (wd),
    .laneWe  (laneWe),
    .laneWd  (laneWd),
    .laneAddr(laneAddr)
  );

  // ------------------------------------------------------------
  // Byte lanes.
  // ------------------------------------------------------------

  // Lane i holds every byte whose address is i modulo 4.
  byteRam #(.addrWidth(laneAddrWidth)) u_lane0 (
    .clk (clk),
    .we  (laneWe[0]),
    .addr(laneAddr[0]),
    .wd  (laneWd[0]),
    .rd  (laneRd[0])
  );

  byteRam #(.addrWidth(laneAddrWidth)) u_lane1 (
    .clk (clk),
    .we  (laneWe[1]),
    .addr(laneAddr[1]),
    .wd  (laneWd[1]),
    .rd  (laneRd[1])
  );

  byteRam #(.addrWidth(laneAddrWidth)) u_lane2 (
    .clk (clk),
    .we  (laneWe[2]),
    .addr(laneAddr[2]),
    .wd  (laneWd[2]),
    .rd  (laneRd[2])
  );

  byteRam #(.addrWidth(laneAddrWidth)) u_lane3 (
    .clk (clk),
    .we  (laneWe[3]),
    .addr(laneAddr[3]),
    .wd  (laneWd[3]),
    .rd  (laneRd[3])
  );

  // ------------------------------------------------------------
  // Read formatting.
  // ------------------------------------------------------------

  loadFormat u_load (
    .clk      (clk),
    .rstN     (rstN),
    .memSize  (memSize),
    .memSigned(memSigned),
    .offset   (addr[offsetWidth-1:0]),
    .laneRd   (laneRd),
    .rd       (rd)
  );

endmodule

`default_nettype wire

// ==== memoryChecker.sv ====
`default_nettype none

// Watches the memory ports and compares rd against a byte model.
module memoryChecker #(
  parameter int sizeLog2 = 6
) (
  input logic                         clk,
  input logic                         rstN,
  input logic                         we,
  input memPkg::memSizeT              memSize,
  input logic                         memSigned,
  input logic [sizeLog2-1:0]          addr,
  input logic [memPkg::wordWidth-1:0] wd,
  input logic [memPkg::wordWidth-1:0] rd
);

  import memPkg::*;

  localparam int memBytes = 2 ** sizeLog2;

  // ------------------------------------------------------------
  // Reference model.
  // ------------------------------------------------------------

  logic [7:0]          model [memBytes];
  logic                known [memBytes];
  logic [31:0]         expRd;
  logic                expValid;
  logic [sizeLog2-1:0] expAddr;
  int                  expBytes;
  int                  checkCount;
  int                  errCount;

  initial begin
    for (int i = 0; i < memBytes; i++) begin
      known[i] = 1'b0;
    end
    expValid   = 1'b0;
    checkCount = 0;
    errCount   = 0;
  end

  function automatic int sizeBytes(input memSizeT s);
    case (s)
      memByte: return 1;
      memHalf: return 2;
      default: return 4;
    endcase
  endfunction

  // True when every byte of the access has been written once.
  function automatic logic allKnown(input int n, input logic [sizeLog2-1:0] a);
    logic ok;
    ok = 1'b1;
    for (int k = 0; k < n; k++) begin
      ok = ok & known[(int'(a) + k) % memBytes];
    end
    return ok;
  endfunction

  // Little endian gather with wrap, then extension.
  function automatic logic [31:0] expectedRead(input int n, input logic sg,
                                               input logic [sizeLog2-1:0] a);
    logic [31:0] value;
    value = '0;
    for (int k = 0; k < n; k++) begin
      value[8*k +: 8] = model[(int'(a) + k) % memBytes];
    end
    if (sg && n < 4) begin
      for (int b = 8 * n; b < 32; b++) begin
        value[b] = value[8*n-1];
      end
    end
    return value;
  endfunction

  // ------------------------------------------------------------
  // Sampling at the rising edge.
  // ------------------------------------------------------------

  // The expected read is taken before this edge's write lands.
  always @(posedge clk) begin
    if (!rstN) begin
      expValid = 1'b0;
    end else begin
      expBytes = sizeBytes(memSize);
      expAddr  = addr;
      expValid = allKnown(expBytes, addr);
      if (expValid) begin
        expRd = expectedRead(expBytes, memSigned, addr);
      end
      if (we) begin
        for (int k = 0; k < expBytes; k++) begin
          model[(int'(addr) + k) % memBytes] = wd[8*k +: 8];
          known[(int'(addr) + k) % memBytes] = 1'b1;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Comparison at the falling edge.
  // ------------------------------------------------------------

  always @(negedge clk) begin
    if (expValid) begin
      checkCount++;
      if (rd !== expRd) begin
        errCount++;
        $display("Fail at time %0t: %0d-byte read at 0x%h returned %h, expected %h",
                 $time, expBytes, expAddr, rd, expRd);
      end
    end
  end

endmodule

`default_nettype wire

// ==== memoryTb.sv ====
`default_nettype none

module memoryTb;

  import memPkg::*;

  localparam int sizeLog2 = 6;
  localparam int memBytes = 2 ** sizeLog2;

  // Planned operations per test.
  localparam int opsFill   = 32;
  localparam int opsNarrow = 60;
  localparam int opsExtend = 256;
  localparam int opsCross  = 192;
  localparam int opsMix    = 400;
  localparam int totalOps  = opsFill + opsNarrow + opsExtend + opsCross + opsMix;
  localparam int cycleLimit = 2 * totalOps + 64;

  logic            clk;
  logic            rstN;
  logic            we;
  memSizeT         memSize;
  logic            memSigned;
  logic [sizeLog2-1:0] addr;
  logic [31:0]     wd;
  logic [31:0]     rd;

  logic [15:0]     lfsr;
  int              cycleCount;
  int              testsPassed;
  int              testsFailed;
  int              errStart;
  int              checkStart;

  memory #(
    .sizeLog2(sizeLog2)
  ) u_dut (
    .clk      (clk),
    .rstN     (rstN),
    .we       (we),
    .memSize  (memSize),
    .memSigned(memSigned),
    .addr     (addr),
    .wd       (wd),
    .rd       (rd)
  );

  memoryChecker #(
    .sizeLog2(sizeLog2)
  ) u_check (
    .clk      (clk),
    .rstN     (rstN),
    .we       (we),
    .memSize  (memSize),
    .memSigned(memSigned),
    .addr     (addr),
    .wd       (wd),
    .rd       (rd)
  );

  // ------------------------------------------------------------
  // Clock and stimulus helpers.
  // ------------------------------------------------------------

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Fibonacci LFSR, taps 16 14 13 11, one step per bit.
  function automatic logic [31:0] randomBits(input int n);
    logic [31:0] result;
    logic        fb;
    result = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr   = {lfsr[14:0], fb};
      result = {result[30:0], fb};
    end
    return result;
  endfunction

  function automatic memSizeT randomSize();
    logic [1:0] code;
    code = 2'(randomBits(2));
    if (code == 2'd3) begin
      return memWord;
    end
    return memSizeT'(code);
  endfunction

  task automatic applyAccess(input logic w, input memSizeT s, input logic sg,
                             input logic [sizeLog2-1:0] a, input logic [31:0] d);
    @(posedge clk);
    we        <= w;
    memSize   <= s;
    memSigned <= sg;
    addr      <= a;
    wd        <= d;
  endtask

  // Idle access, then let the last read reach the checker.
  task automatic drain();
    applyAccess(1'b0, memWord, 1'b0, '0, '0);
    @(posedge clk);
    @(posedge clk);
  endtask

  task automatic startTest();
    errStart   = u_check.errCount;
    checkStart = u_check.checkCount;
  endtask

  task automatic endTest(input int num, input string name);
    int errs;
    int checks;
    drain();
    errs   = u_check.errCount - errStart;
    checks = u_check.checkCount - checkStart;
    if (checks == 0) begin
      $display("Test %0d %s: no read was compared, so nothing was checked", num, name);
      testsFailed++;
    end else if (errs == 0) begin
      $display("Test %0d %s: passed, %0d reads checked", num, name, checks);
      testsPassed++;
    end else begin
      $display("Test %0d %s: failed, %0d of %0d reads wrong", num, name, errs, checks);
      testsFailed++;
    end
  endtask

  // ------------------------------------------------------------
  // Timeout.
  // ------------------------------------------------------------

  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Run timed out after %0d cycles", cycleCount);
    $display("Test FAILED");
    $finish;
  end

  // ------------------------------------------------------------
  // Test sequence.
  // ------------------------------------------------------------

  initial begin
    logic [sizeLog2-1:0] a;
    memSizeT             s;
    lfsr        = 16'd57535;
    testsPassed = 0;
    testsFailed = 0;
    rstN        = 1'b0;
    we          = 1'b0;
    memSize     = memByte;
    memSigned   = 1'b0;
    addr        = '0;
    wd          = '0;
    repeat (8) @(posedge clk);
    rstN <= 1'b1;

    // Aligned word fill and readback.
    startTest();
    for (int w = 0; w < memBytes / 4; w++) begin
      applyAccess(1'b1, memWord, 1'b0, sizeLog2'(4 * w), randomBits(32));
    end
    for (int w = 0; w < memBytes / 4; w++) begin
      applyAccess(1'b0, memWord, 1'b0, sizeLog2'(4 * w), '0);
    end
    endTest(1, "aligned words");

    // Narrow writes, neighbours checked through word reads.
    startTest();
    for (int i = 0; i < opsNarrow / 3; i++) begin
      a = sizeLog2'(randomBits(sizeLog2));
      s = randomBits(1) ? memHalf : memByte;
      applyAccess(1'b1, s, 1'b0, a, randomBits(32));
      applyAccess(1'b0, memWord, 1'b0, {a[sizeLog2-1:2], 2'b00}, '0);
      applyAccess(1'b0, memWord, 1'b0, {a[sizeLog2-1:2] + 1'b1, 2'b00}, '0);
    end
    endTest(2, "narrow writes");

    // Byte and halfword reads at every offset, both extensions.
    startTest();
    for (int b = 0; b < memBytes; b++) begin
      applyAccess(1'b0, memByte, 1'b0, sizeLog2'(b), '0);
      applyAccess(1'b0, memByte, 1'b1, sizeLog2'(b), '0);
      applyAccess(1'b0, memHalf, 1'b0, sizeLog2'(b), '0);
      applyAccess(1'b0, memHalf, 1'b1, sizeLog2'(b), '0);
    end
    endTest(3, "load extension");

    // Unaligned accesses across words, the last word wraps.
    startTest();
    for (int w = 0; w < memBytes / 4; w++) begin
      for (int off = 1; off < 4; off++) begin
        a = sizeLog2'(4 * w + off);
        applyAccess(1'b1, memHalf, 1'b0, a, randomBits(32));
        applyAccess(1'b0, memHalf, 1'(randomBits(1)), a, '0);
        applyAccess(1'b1, memWord, 1'b0, a, randomBits(32));
        applyAccess(1'b0, memWord, 1'b0, a, '0);
      end
    end
    endTest(4, "unaligned crossing");

    // Random mix, a write cycle also reads the old contents.
    startTest();
    for (int i = 0; i < opsMix; i++) begin
      applyAccess(1'(randomBits(1)), randomSize(), 1'(randomBits(1)),
                  sizeLog2'(randomBits(sizeLog2)), randomBits(32));
    end
    endTest(5, "random mix");

    $display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
    if (testsFailed == 0 && u_check.errCount == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== memory.f ====
memPkg.sv
byteRam.sv
storeSteer.sv
loadFormat.sv
memory.sv
memoryChecker.sv
memoryTb.sv
